/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = arcade_host_tb
FILELIST  = dig_dug_host.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dig_dug_host.f */
rtl/cabinet_pkg.sv
rtl/video_pkg.sv
rtl/key_decoder.sv
rtl/cabinet_controls.sv
rtl/video_output.sv
rtl/audio_dac.sv
rtl/arcade_host.sv
verification/arcade_host_tb.sv

/* rtl/arcade_host.sv */
`timescale 1ns/1ps
`default_nettype none

module arcade_host #(
	parameter int dac_width = 16
) (
	input  wire logic                              clock_48,
	input  wire logic                              reset,
	input  wire logic                              key_strobe,
	input  wire logic [7:0]                        key_code,
	input  wire logic                              key_pressed,
	input  wire cabinet_pkg::joy_t                 joystick_0,
	input  wire cabinet_pkg::joy_t                 joystick_1,
	input  wire logic [cabinet_pkg::status_width-1:0] status,
	input  wire logic                              buttons_menu,
	input  wire logic                              ioctl_downl,
	input  wire video_pkg::core_video_t            core_video,
	input  wire logic [7:0]                        core_audio,
	output cabinet_pkg::core_inputs_t              core_inputs,
	output cabinet_pkg::dip_switches_t             dip_switches,
	output logic                                   core_reset,
	output video_pkg::vga_out_t                    vga,
	output logic                                   audio_left,
	output logic                                   audio_right,
	output logic                                   led
);

	cabinet_pkg::key_buttons_t key_buttons;
	video_pkg::scanline_t      scanlines;

	assign scanlines   = video_pkg::scanline_t'(
		status[cabinet_pkg::st_scan_hi:cabinet_pkg::st_scan_lo]);
	assign audio_right = audio_left; // mono core
	assign led         = ~ioctl_downl; // lit while idle

	key_decoder u_key_decoder (
		.clock_48    (clock_48),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_code    (key_code),
		.key_pressed (key_pressed),
		.buttons     (key_buttons)
	);

	cabinet_controls u_cabinet_controls (
		.clock_48     (clock_48),
		.reset        (reset),
		.buttons      (key_buttons),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.buttons_menu (buttons_menu),
		.ioctl_downl  (ioctl_downl),
		.core_inputs  (core_inputs),
		.dip_switches (dip_switches),
		.core_reset   (core_reset)
	);

	video_output u_video_output (
		.clock_48  (clock_48),
		.reset     (reset),
		.video_in  (core_video),
		.scanlines (scanlines),
		.video_out (vga)
	);

	audio_dac #(
		.dac_width (dac_width)
	) u_audio_dac (
		.clock_48  (clock_48),
		.reset     (reset),
		.sample    (core_audio),
		.audio_out (audio_left)
	);

endmodule

`default_nettype wire

/* rtl/audio_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dac #(
	parameter int dac_width = 16
) (
	input  wire logic       clock_48,
	input  wire logic       reset,
	input  wire logic [7:0] sample,
	output logic            audio_out
);

	localparam int repeats = (dac_width + 7) / 8;

	logic [repeats*8-1:0] sample_rep;
	logic [dac_width-1:0] level;
	logic [dac_width-1:0] acc;
	logic [dac_width:0]   sum;

	assign sample_rep = {repeats{sample}};
	assign level      = sample_rep[repeats*8-1 -: dac_width]; // full scale at ffh
	assign sum        = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clock_48) begin
		if (reset) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= sum[dac_width-1:0];
			audio_out <= sum[dac_width]; // carry is the pulse density
		end
	end

endmodule

`default_nettype wire

/* rtl/cabinet_controls.sv */
`timescale 1ns/1ps
`default_nettype none

module cabinet_controls (
	input  wire logic                              clock_48,
	input  wire logic                              reset,
	input  wire cabinet_pkg::key_buttons_t         buttons,
	input  wire cabinet_pkg::joy_t                 joystick_0,
	input  wire cabinet_pkg::joy_t                 joystick_1,
	input  wire logic [cabinet_pkg::status_width-1:0] status,
	input  wire logic                              buttons_menu,
	input  wire logic                              ioctl_downl,
	output cabinet_pkg::core_inputs_t              core_inputs,
	output cabinet_pkg::dip_switches_t             dip_switches,
	output logic                                   core_reset
);

	cabinet_pkg::core_inputs_t  inputs_next;
	cabinet_pkg::dip_switches_t dips_next;
	logic [1:0] difficulty;
	logic [1:0] lives;
	logic [2:0] bonus;
	logic       downl_prev;
	logic       rom_loaded;

	// menu order differs from the switch codes
	assign difficulty = status[cabinet_pkg::st_diff_hi:cabinet_pkg::st_diff_lo] + 2'd2;
	assign lives      = status[cabinet_pkg::st_lives_hi:cabinet_pkg::st_lives_lo] + 2'd2;
	assign bonus      = status[cabinet_pkg::st_bonus_hi:cabinet_pkg::st_bonus_lo] + 3'd3;

	always_comb begin
		inputs_next.inp0 = {status[cabinet_pkg::st_service], 2'b00, buttons.coin,
			buttons.start2, buttons.start1, joystick_1.fire,
			buttons.fire1 | joystick_0.fire};
		inputs_next.inp1 = {joystick_1.left, joystick_1.down, joystick_1.right, joystick_1.up,
			buttons.left | joystick_0.left, buttons.down | joystick_0.down,
			buttons.right | joystick_0.right, buttons.up | joystick_0.up};
		dips_next.dsw0 = {lives, bonus, cabinet_pkg::dip_coin_b};
		dips_next.dsw1 = {cabinet_pkg::dip_coin_a, cabinet_pkg::dip_freeze,
			~status[cabinet_pkg::st_demo_sound], ~status[cabinet_pkg::st_continue],
			cabinet_pkg::dip_cabinet, difficulty};
	end

	always_ff @(posedge clock_48) begin
		downl_prev <= ioctl_downl;
	end

	always_ff @(posedge clock_48) begin
		if (reset) begin
			core_inputs  <= '0;
			dip_switches <= '0;
			rom_loaded   <= 1'b0;
			core_reset   <= 1'b1;
		end else begin
			core_inputs  <= inputs_next;
			dip_switches <= dips_next;
			if (downl_prev && !ioctl_downl)
				rom_loaded <= 1'b1; // download finished
			core_reset <= status[cabinet_pkg::st_reset] | status[cabinet_pkg::st_menu_reset]
				| buttons_menu | ~rom_loaded;
		end
	end

	// core never runs on a partly loaded rom
	core_held_until_loaded: assert property (@(posedge clock_48) disable iff (reset)
		!rom_loaded |-> core_reset);

endmodule

`default_nettype wire

/* rtl/cabinet_pkg.sv */
`default_nettype none

package cabinet_pkg;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic coin;
		logic start1;
		logic start2;
	} key_buttons_t;

	typedef struct packed {
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef struct packed {
		logic [7:0] inp0;
		logic [7:0] inp1;
	} core_inputs_t;

	typedef struct packed {
		logic [7:0] dsw0;
		logic [7:0] dsw1;
	} dip_switches_t;

	// ps/2 set 2 make codes
	localparam logic [7:0] scan_up     = 8'h75;
	localparam logic [7:0] scan_down   = 8'h72;
	localparam logic [7:0] scan_left   = 8'h6b;
	localparam logic [7:0] scan_right  = 8'h74;
	localparam logic [7:0] scan_coin   = 8'h76; // esc
	localparam logic [7:0] scan_start1 = 8'h05; // f1
	localparam logic [7:0] scan_start2 = 8'h06; // f2
	localparam logic [7:0] scan_fire1  = 8'h29; // space

	localparam int status_width  = 32;
	localparam int st_reset      = 0;
	localparam int st_scan_lo    = 3;
	localparam int st_scan_hi    = 4;
	localparam int st_menu_reset = 6;
	localparam int st_diff_lo    = 8;
	localparam int st_diff_hi    = 9;
	localparam int st_lives_lo   = 10;
	localparam int st_lives_hi   = 11;
	localparam int st_bonus_lo   = 12;
	localparam int st_bonus_hi   = 14;
	localparam int st_continue   = 15;
	localparam int st_demo_sound = 16;
	localparam int st_service    = 17;

	// switches with no menu entry
	localparam logic [1:0] dip_coin_a  = 2'd0; // 1 coin 1 credit
	localparam logic [2:0] dip_coin_b  = 3'd1;
	localparam logic       dip_cabinet = 1'b1;
	localparam logic       dip_freeze  = 1'b1;

endpackage

`default_nettype wire

/* rtl/key_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input  wire logic                  clock_48,
	input  wire logic                  reset,
	input  wire logic                  key_strobe,
	input  wire logic [7:0]            key_code,
	input  wire logic                  key_pressed,
	output cabinet_pkg::key_buttons_t  buttons
);

	logic strobe_prev;
	logic key_event;

	// strobe toggles once per key event
	assign key_event = (key_strobe != strobe_prev);

	always_ff @(posedge clock_48) begin
		strobe_prev <= key_strobe;
	end

	always_ff @(posedge clock_48) begin
		if (reset) begin
			buttons <= '0;
		end else if (key_event) begin
			case (key_code)
				cabinet_pkg::scan_up:     buttons.up     <= key_pressed;
				cabinet_pkg::scan_down:   buttons.down   <= key_pressed;
				cabinet_pkg::scan_left:   buttons.left   <= key_pressed;
				cabinet_pkg::scan_right:  buttons.right  <= key_pressed;
				cabinet_pkg::scan_coin:   buttons.coin   <= key_pressed;
				cabinet_pkg::scan_start1: buttons.start1 <= key_pressed;
				cabinet_pkg::scan_start2: buttons.start2 <= key_pressed;
				cabinet_pkg::scan_fire1:  buttons.fire1  <= key_pressed;
				default: ; // other keys ignored
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/video_output.sv */
`timescale 1ns/1ps
`default_nettype none

module video_output (
	input  wire logic                    clock_48,
	input  wire logic                    reset,
	input  wire video_pkg::core_video_t  video_in,
	input  wire video_pkg::scanline_t    scanlines,
	output video_pkg::vga_out_t          video_out
);

	logic [3:0]           red_1;
	logic [3:0]           green_1;
	logic [3:0]           blue_1;
	logic                 hs_1;
	logic                 vs_1;
	logic                 odd_1;
	video_pkg::scanline_t mode_1;
	logic                 blank;

	// widen to 6 bits then darken odd lines
	function automatic logic [5:0] expand_dim(input logic [3:0] c4, input logic odd,
		input video_pkg::scanline_t mode);
		logic [5:0] c6;
		logic [5:0] result;
		c6 = {c4, c4[3:2]};
		result = c6;
		if (odd) begin
			case (mode)
				video_pkg::scan_quarter:       result = c6 - (c6 >> 2);
				video_pkg::scan_half:          result = c6 - (c6 >> 1);
				video_pkg::scan_three_quarter: result = c6 - ((c6 >> 1) + (c6 >> 2));
				default:                       result = c6;
			endcase
		end
		return result;
	endfunction

	assign blank = video_in.hblank | video_in.vblank;

	// stage 1 does 4 bit colour and blanking
	always_ff @(posedge clock_48) begin
		if (reset) begin
			red_1   <= '0;
			green_1 <= '0;
			blue_1  <= '0;
			hs_1    <= 1'b0;
			vs_1    <= 1'b0;
			odd_1   <= 1'b0;
			mode_1  <= video_pkg::scan_none;
		end else begin
			red_1   <= blank ? 4'd0 : {video_in.pixel[2:0], 1'b0};
			green_1 <= blank ? 4'd0 : {video_in.pixel[5:3], 1'b0};
			blue_1  <= blank ? 4'd0 : {video_in.pixel[7:6], 2'b00};
			hs_1    <= video_in.hsync;
			vs_1    <= video_in.vsync;
			odd_1   <= video_in.odd_line;
			mode_1  <= scanlines; // mode follows its pixel
		end
	end

	// stage 2
	always_ff @(posedge clock_48) begin
		if (reset) begin
			video_out <= '0;
		end else begin
			video_out.r  <= expand_dim(red_1, odd_1, mode_1);
			video_out.g  <= expand_dim(green_1, odd_1, mode_1);
			video_out.b  <= expand_dim(blue_1, odd_1, mode_1);
			video_out.hs <= hs_1;
			video_out.vs <= vs_1;
		end
	end

	blanked_pixel_black: assert property (@(posedge clock_48) disable iff (reset)
		(video_in.hblank || video_in.vblank) |-> ##2
		(video_out.r == 6'd0 && video_out.g == 6'd0 && video_out.b == 6'd0));

endmodule

`default_nettype wire

/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

	typedef struct packed {
		logic [7:0] pixel; // bbgggrrr
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
		logic       odd_line;
	} core_video_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_out_t;

	typedef enum logic [1:0] {
		scan_none          = 2'd0,
		scan_quarter       = 2'd1,
		scan_half          = 2'd2,
		scan_three_quarter = 2'd3
	} scanline_t;

endpackage

`default_nettype wire

/* verification/arcade_host_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module arcade_host_tb;

	localparam int clock_period  = 20;
	localparam int video_cycles  = 200;
	localparam int total_cycles  = 80 + 400 + 300 + 4 * video_cycles + 3 * (5 + 65536);
	localparam int margin_cycles = 2000;
	localparam logic [7:0] key_table [8] = '{8'h75, 8'h72, 8'h6b, 8'h74,
		8'h76, 8'h05, 8'h06, 8'h29};

	logic                       clock_48 = 1'b0;
	logic                       reset;
	logic                       key_strobe;
	logic [7:0]                 key_code;
	logic                       key_pressed;
	cabinet_pkg::joy_t          joystick_0;
	cabinet_pkg::joy_t          joystick_1;
	logic [31:0]                status;
	logic                       buttons_menu;
	logic                       ioctl_downl;
	video_pkg::core_video_t     core_video;
	logic [7:0]                 core_audio;
	cabinet_pkg::core_inputs_t  core_inputs;
	cabinet_pkg::dip_switches_t dip_switches;
	logic                       core_reset;
	video_pkg::vga_out_t        vga;
	logic                       audio_left;
	logic                       audio_right;
	logic                       led;

	integer seed;
	int     error_count = 0;
	int     check_count = 0;

	// reference model state
	logic                       m_strobe_prev;
	logic                       m_downl_prev;
	logic                       m_rom_loaded;
	logic                       m_core_reset;
	cabinet_pkg::key_buttons_t  m_buttons;
	cabinet_pkg::core_inputs_t  m_inputs;
	cabinet_pkg::dip_switches_t m_dips;
	video_pkg::core_video_t     m_video_1;
	logic [1:0]                 m_mode_1;
	video_pkg::vga_out_t        m_vga;
	logic [15:0]                m_acc;
	logic                       m_audio;

	always #(clock_period / 2) clock_48 = ~clock_48;

	arcade_host u_dut (
		.clock_48     (clock_48),
		.reset        (reset),
		.key_strobe   (key_strobe),
		.key_code     (key_code),
		.key_pressed  (key_pressed),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.status       (status),
		.buttons_menu (buttons_menu),
		.ioctl_downl  (ioctl_downl),
		.core_video   (core_video),
		.core_audio   (core_audio),
		.core_inputs  (core_inputs),
		.dip_switches (dip_switches),
		.core_reset   (core_reset),
		.vga          (vga),
		.audio_left   (audio_left),
		.audio_right  (audio_right),
		.led          (led)
	);

	function automatic cabinet_pkg::key_buttons_t apply_key(input cabinet_pkg::key_buttons_t b,
		input logic [7:0] code, input logic pressed);
		case (code)
			8'h75: b.up = pressed;
			8'h72: b.down = pressed;
			8'h6b: b.left = pressed;
			8'h74: b.right = pressed;
			8'h76: b.coin = pressed;
			8'h05: b.start1 = pressed;
			8'h06: b.start2 = pressed;
			8'h29: b.fire1 = pressed;
			default: ;
		endcase
		return b;
	endfunction

	function automatic cabinet_pkg::core_inputs_t expected_inputs(
		input cabinet_pkg::key_buttons_t b, input cabinet_pkg::joy_t j0,
		input cabinet_pkg::joy_t j1, input logic [31:0] st);
		cabinet_pkg::core_inputs_t i;
		i.inp0 = {st[17], 2'b00, b.coin, b.start2, b.start1, j1.fire, b.fire1 | j0.fire};
		i.inp1 = {j1.left, j1.down, j1.right, j1.up,
			b.left | j0.left, b.down | j0.down, b.right | j0.right, b.up | j0.up};
		return i;
	endfunction

	function automatic cabinet_pkg::dip_switches_t expected_dips(input logic [31:0] st);
		cabinet_pkg::dip_switches_t d;
		d.dsw0 = {st[11:10] + 2'd2, st[14:12] + 3'd3, 3'd1}; // coin b fixed
		d.dsw1 = {2'd0, 1'b1, ~st[16], ~st[15], 1'b1, st[9:8] + 2'd2};
		return d;
	endfunction

	function automatic logic [5:0] dim_channel(input logic [3:0] c4, input logic odd,
		input logic [1:0] mode);
		logic [5:0] c6;
		logic [5:0] quarter;
		logic [5:0] half;
		c6 = {c4, c4[3:2]};
		quarter = c6 >> 2;
		half = c6 >> 1;
		if (!odd || mode == 2'd0)
			return c6;
		else if (mode == 2'd1)
			return c6 - quarter;
		else if (mode == 2'd2)
			return c6 - half;
		return c6 - half - quarter;
	endfunction

	function automatic video_pkg::vga_out_t expected_vga(input video_pkg::core_video_t v,
		input logic [1:0] mode);
		video_pkg::vga_out_t o;
		logic blank;
		blank = v.hblank | v.vblank;
		o.r = dim_channel(blank ? 4'd0 : {v.pixel[2:0], 1'b0}, v.odd_line, mode);
		o.g = dim_channel(blank ? 4'd0 : {v.pixel[5:3], 1'b0}, v.odd_line, mode);
		o.b = dim_channel(blank ? 4'd0 : {v.pixel[7:6], 2'b00}, v.odd_line, mode);
		o.hs = v.hsync;
		o.vs = v.vsync;
		return o;
	endfunction

	always @(posedge clock_48) begin
		m_strobe_prev <= key_strobe;
		m_downl_prev  <= ioctl_downl;
		if (reset) begin
			m_buttons    <= '0;
			m_inputs     <= '0;
			m_dips       <= '0;
			m_rom_loaded <= 1'b0;
			m_core_reset <= 1'b1;
			m_video_1    <= '0;
			m_mode_1     <= 2'd0;
			m_vga        <= '0;
			m_acc        <= '0;
			m_audio      <= 1'b0;
		end else begin
			if (key_strobe != m_strobe_prev)
				m_buttons <= apply_key(m_buttons, key_code, key_pressed);
			m_inputs <= expected_inputs(m_buttons, joystick_0, joystick_1, status);
			m_dips   <= expected_dips(status);
			if (m_downl_prev && !ioctl_downl)
				m_rom_loaded <= 1'b1;
			m_core_reset <= status[0] | status[6] | buttons_menu | ~m_rom_loaded;
			m_video_1    <= core_video;
			m_mode_1     <= status[4:3];
			m_vga        <= expected_vga(m_video_1, m_mode_1);
			{m_audio, m_acc} <= {1'b0, m_acc} + {1'b0, core_audio, core_audio}; // carry out
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERR %s: got 0x%h expected 0x%h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic check_outputs();
		check_value("core_inputs", {16'd0, core_inputs}, {16'd0, m_inputs});
		check_value("dip_switches", {16'd0, dip_switches}, {16'd0, m_dips});
		check_value("core_reset", {31'd0, core_reset}, {31'd0, m_core_reset});
		check_value("vga", {12'd0, vga}, {12'd0, m_vga});
		check_value("audio_left", {31'd0, audio_left}, {31'd0, m_audio});
		check_value("audio_right", {31'd0, audio_right}, {31'd0, m_audio});
		check_value("led", {31'd0, led}, {31'd0, ~ioctl_downl});
	endtask

	// inputs change after a rising edge and outputs are read at the falling edge
	task automatic tick();
		@(negedge clock_48);
		check_outputs();
		@(posedge clock_48);
	endtask

	task automatic check_rom_download();
		logic [31:0] rnd;
		ioctl_downl <= 1'b1;
		repeat (20) begin
			@(negedge clock_48);
			check_outputs();
			check_value("core_reset", {31'd0, core_reset}, 32'd1); // held while loading
			@(posedge clock_48);
		end
		ioctl_downl <= 1'b0;
		repeat (2) tick();
		@(negedge clock_48);
		check_value("core_reset", {31'd0, core_reset}, 32'd0);
		@(posedge clock_48);
		repeat (40) begin
			rnd = $random(seed);
			status       <= {25'd0, rnd[1], 5'd0, rnd[0]};
			buttons_menu <= (rnd[4:2] == 3'd0);
			tick();
		end
	endtask

	task automatic run_key_events(input int count);
		logic [31:0] rnd;
		logic [31:0] rnd2;
		for (int i = 0; i < count; i++) begin
			rnd  = $random(seed);
			rnd2 = $random(seed);
			if (rnd[0])
				key_strobe <= ~key_strobe;
			key_code    <= (rnd[3:2] == 2'b00) ? rnd[15:8] : key_table[rnd[6:4]];
			key_pressed <= rnd[1];
			joystick_0  <= rnd2[4:0];
			joystick_1  <= rnd2[9:5];
			status      <= {14'd0, rnd2[17], 17'd0}; // service bit only
			tick();
		end
	endtask

	task automatic run_status_words(input int count);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			status       <= rnd;
			buttons_menu <= (rnd[20] & rnd[21]);
			tick();
		end
	endtask

	task automatic run_video(input logic [1:0] mode, input int count);
		logic [31:0]            rnd;
		logic [31:0]            st;
		video_pkg::core_video_t v;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			st  = $random(seed);
			st[4:3]    = mode;
			v.pixel    = rnd[7:0];
			v.hblank   = (rnd[10:8] == 3'd0);
			v.vblank   = (rnd[13:11] == 3'd0);
			v.hsync    = rnd[14];
			v.vsync    = rnd[15];
			v.odd_line = rnd[16];
			core_video <= v;
			status     <= st;
			tick();
		end
	endtask

	task automatic audio_density(input logic [7:0] sample);
		int ones;
		ones = 0;
		reset      <= 1'b1;
		core_audio <= sample;
		repeat (3) tick();
		reset <= 1'b0;
		tick(); // still shows the reset state
		repeat (65536) begin
			@(negedge clock_48);
			check_outputs();
			if (audio_left)
				ones++;
			@(posedge clock_48);
		end
		check_value("audio_left ones", ones, {16'd0, sample, sample});
	endtask

	initial begin
		seed = 20;
		reset        <= 1'b1;
		key_strobe   <= 1'b0;
		key_code     <= 8'd0;
		key_pressed  <= 1'b0;
		joystick_0   <= '0;
		joystick_1   <= '0;
		status       <= 32'd0;
		buttons_menu <= 1'b0;
		ioctl_downl  <= 1'b0;
		core_video   <= '0;
		core_audio   <= 8'd0;
		repeat (3) @(posedge clock_48);
		reset <= 1'b0;
		@(negedge clock_48);
		check_value("core_reset", {31'd0, core_reset}, 32'd1);
		check_value("vga", {12'd0, vga}, 32'd0);
		check_value("audio_left", {31'd0, audio_left}, 32'd0);
		check_outputs();
		@(posedge clock_48);
		check_rom_download();
		run_key_events(400);
		run_status_words(300);
		for (int m = 0; m < 4; m++)
			run_video(m[1:0], video_cycles);
		audio_density(8'h00);
		audio_density(8'h80);
		audio_density(8'hff);
		$display("checks: %0d errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(clock_period * (total_cycles + margin_cycles));
		$display("timeout: tests did not finish within %0d cycles", total_cycles + margin_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
